//--- verilog/ddr2_timing_pkg.sv
package ddr2_timing_pkg;

  // Address widths of the memory device
  localparam int BANK_W = 2;
  localparam int ROW_W  = 14;
  localparam int COL_W  = 10;

  // Core timing, counted in ddr_clk_0 cycles
  localparam int T_RCD = 4;           // ACT to RD or WR
  localparam int T_RP  = 4;           // PRE or PREA to next ACT or REF
  localparam int T_RFC = 26;          // REF to any other command
  localparam int T_MRD = 2;           // MRS to next command

  // Much shorter than the real 200 us so that simulation stays quick
  localparam int T_INIT_WAIT = 40;

  // MR word with burst length 4, sequential bursts, CAS latency 4 and write recovery 4
  localparam logic [ROW_W-1:0] MR_VALUE = 14'h0642;

  // EMR word with the DLL enabled, full drive strength and 75 ohm ODT
  localparam logic [ROW_W-1:0] EMR_VALUE = 14'h0004;

  // The column address always sits in the low bits of the row field
  localparam int COL_PAD_W = ROW_W - COL_W;

endpackage

//--- verilog/ddr2_cmd_pkg.sv
package ddr2_cmd_pkg;

  // Command on the DDR2 bus, decoded from RAS, CAS and WE by the PHY
  typedef enum logic [2:0] {
    NOP  = 3'd0,
    MRS  = 3'd1,
    REF  = 3'd2,
    PRE  = 3'd3,
    PREA = 3'd4,
    ACT  = 3'd5,
    WR   = 3'd6,
    RD   = 3'd7
  } ddr2_cmd_e;

  // Mode register layout from A13 down to A0
  typedef struct packed {
    logic [1:0] rsvd;                 // A13 and the power-down exit bit
    logic [2:0] wr;                   // Write recovery minus one
    logic       dll_rst;
    logic       tm;                   // Test mode stays low
    logic [2:0] cl;                   // CAS latency
    logic       bt;                   // Burst type, low is sequential
    logic [2:0] bl;                   // Burst length code
  } ddr2_mode_t;

  // The address pins carry either a row or column, or a mode word during MRS
  typedef union packed {
    logic [ddr2_timing_pkg::ROW_W-1:0] row;
    ddr2_mode_t                        mode;
  } ddr2_addr_u;

  typedef struct packed {
    ddr2_cmd_e                          cmd;
    logic [ddr2_timing_pkg::BANK_W-1:0] ba;   // Bank, or mode register select on MRS
    ddr2_addr_u                         addr;
  } ddr2_cmd_t;

  typedef struct packed {
    logic                               wr;   // High for a write, low for a read
    logic [ddr2_timing_pkg::BANK_W-1:0] bank;
    logic [ddr2_timing_pkg::ROW_W-1:0]  row;
    logic [ddr2_timing_pkg::COL_W-1:0]  col;
  } ddr2_req_t;

  localparam ddr2_cmd_t CMD_NOP = '0;

endpackage

//--- verilog/ddr2_reset_gen.sv
`timescale 1ns/1ps

module ddr2_reset_gen #(
  parameter int RST_STAGES = 8
) (
  input  logic ddr_clk_0,
  input  logic reset_int,
  input  logic usr_rst,
  input  logic pll_locked,
  output logic ctrl_rst
);

  logic                  rst_src;
  logic [RST_STAGES-1:0] rst_shift;

  // Any source holds the controller in reset, including a clock that has lost lock
  assign rst_src = reset_int | usr_rst | ~pll_locked;

  always_ff @(posedge ddr_clk_0) begin
    if (rst_src) begin
      rst_shift <= '1;                                    // Refill on every reset cycle
    end else begin
      rst_shift <= {rst_shift[RST_STAGES-2:0], 1'b0};     // Zeros walk towards the top
    end
  end

  // The top stage only clears after every stage has seen a clean cycle
  assign ctrl_rst = rst_shift[RST_STAGES-1];

endmodule

//--- verilog/ddr2_init_seq.sv
`timescale 1ns/1ps

module ddr2_init_seq (
  input  logic                    ddr_clk_0,
  input  logic                    ctrl_rst,
  output ddr2_cmd_pkg::ddr2_cmd_t init_cmd,
  output logic                    init_done
);

  localparam int WAIT_W = $clog2(ddr2_timing_pkg::T_INIT_WAIT + ddr2_timing_pkg::T_RFC);
  localparam logic [3:0] LAST_STEP = 4'd10;

  logic [3:0]              step;
  logic [WAIT_W-1:0]       wait_cnt;
  ddr2_cmd_pkg::ddr2_cmd_t step_cmd;
  logic [WAIT_W-1:0]       step_gap;

  // Command and following gap for each step of the JEDEC power-up list
  always_comb begin
    step_cmd = ddr2_cmd_pkg::CMD_NOP;
    step_gap = WAIT_W'(ddr2_timing_pkg::T_MRD);
    case (step)
      4'd0, 4'd5: begin
        step_cmd.cmd = ddr2_cmd_pkg::PREA;
        step_gap     = WAIT_W'(ddr2_timing_pkg::T_RP);
      end
      4'd1: begin
        step_cmd.cmd = ddr2_cmd_pkg::MRS;                 // EMR2 cleared
        step_cmd.ba  = 2'd2;
      end
      4'd2: begin
        step_cmd.cmd = ddr2_cmd_pkg::MRS;                 // EMR3 cleared
        step_cmd.ba  = 2'd3;
      end
      4'd3, 4'd9: begin
        step_cmd.cmd       = ddr2_cmd_pkg::MRS;           // EMR with the DLL enabled
        step_cmd.ba        = 2'd1;
        step_cmd.addr.mode = ddr2_cmd_pkg::ddr2_mode_t'(ddr2_timing_pkg::EMR_VALUE);
      end
      4'd4: begin
        step_cmd.cmd               = ddr2_cmd_pkg::MRS;
        step_cmd.ba                = 2'd0;
        step_cmd.addr.mode         = ddr2_cmd_pkg::ddr2_mode_t'(ddr2_timing_pkg::MR_VALUE);
        step_cmd.addr.mode.dll_rst = 1'b1;                // First MR write resets the DLL
      end
      4'd6, 4'd7: begin
        step_cmd.cmd = ddr2_cmd_pkg::REF;
        step_gap     = WAIT_W'(ddr2_timing_pkg::T_RFC);
      end
      4'd8: begin
        step_cmd.cmd       = ddr2_cmd_pkg::MRS;           // MR again without DLL reset
        step_cmd.ba        = 2'd0;
        step_cmd.addr.mode = ddr2_cmd_pkg::ddr2_mode_t'(ddr2_timing_pkg::MR_VALUE);
      end
      default: begin
        step_cmd = ddr2_cmd_pkg::CMD_NOP;
      end
    endcase
  end

  always_ff @(posedge ddr_clk_0) begin
    if (ctrl_rst) begin
      step      <= '0;
      wait_cnt  <= WAIT_W'(ddr2_timing_pkg::T_INIT_WAIT - 1);
      init_cmd  <= ddr2_cmd_pkg::CMD_NOP;
      init_done <= 1'b0;
    end else begin
      init_cmd <= ddr2_cmd_pkg::CMD_NOP;                  // NOP between commands
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else if (!init_done) begin
        if (step == LAST_STEP) begin
          init_done <= 1'b1;                              // Gap after the last MRS has run out
        end else begin
          init_cmd <= step_cmd;
          wait_cnt <= step_gap - 1'b1;
          step     <= step + 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/ddr2_refresh_timer.sv
`timescale 1ns/1ps

module ddr2_refresh_timer #(
  parameter int REFI_CYCLES = 1040
) (
  input  logic ddr_clk_0,
  input  logic ctrl_rst,
  input  logic init_done,
  input  logic ref_ack,
  output logic ref_pending
);

  localparam int CNT_W = $clog2(REFI_CYCLES);
  localparam logic [3:0] PEND_MAX = 4'd8;     // DDR2 allows eight refreshes to be postponed

  logic [CNT_W-1:0] refi_cnt;
  logic [3:0]       pend_cnt;
  logic             refi_tick;

  assign refi_tick = init_done && (refi_cnt == CNT_W'(REFI_CYCLES - 1));

  always_ff @(posedge ddr_clk_0) begin
    if (ctrl_rst) begin
      refi_cnt <= '0;
      pend_cnt <= '0;
    end else begin
      if (init_done) begin
        refi_cnt <= refi_tick ? '0 : refi_cnt + 1'b1;
      end
      case ({refi_tick && (pend_cnt != PEND_MAX), ref_ack && (pend_cnt != '0)})
        2'b10:   pend_cnt <= pend_cnt + 1'b1;
        2'b01:   pend_cnt <= pend_cnt - 1'b1;
        default: pend_cnt <= pend_cnt;                // A tick and an ack cancel out
      endcase
    end
  end

  assign ref_pending = (pend_cnt != '0);

endmodule

//--- verilog/ddr2_cmd_sched.sv
`timescale 1ns/1ps

module ddr2_cmd_sched (
  input  logic                    ddr_clk_0,
  input  logic                    ctrl_rst,
  input  ddr2_cmd_pkg::ddr2_cmd_t init_cmd,
  input  logic                    init_done,
  input  logic                    ref_pending,
  input  logic                    req_strobe,
  input  ddr2_cmd_pkg::ddr2_req_t req,
  output logic                    busy,
  output logic                    ref_ack,
  output ddr2_cmd_pkg::ddr2_cmd_t cmd
);

  localparam int DLY_W     = $clog2(ddr2_timing_pkg::T_RFC);
  localparam int NUM_BANKS = 2 ** ddr2_timing_pkg::BANK_W;

  typedef enum logic [2:0] {
    S_INIT,
    S_IDLE,
    S_PREA_WAIT,
    S_RFC,
    S_PRE_WAIT,
    S_ACT_WAIT,
    S_LAST
  } state_e;

  state_e                            state;
  logic [DLY_W-1:0]                  dly;
  logic [NUM_BANKS-1:0]              open_vld;
  logic [ddr2_timing_pkg::ROW_W-1:0] open_row [NUM_BANKS];
  ddr2_cmd_pkg::ddr2_req_t           req_q;
  ddr2_cmd_pkg::ddr2_req_t           act_req;
  ddr2_cmd_pkg::ddr2_cmd_t           cmd_q;
  logic                              accept;
  logic                              row_hit;
  logic                              issue_act;
  logic                              issue_ref;

  function automatic ddr2_cmd_pkg::ddr2_cmd_t col_cmd(input ddr2_cmd_pkg::ddr2_req_t r);
    ddr2_cmd_pkg::ddr2_cmd_t c;
    c.cmd      = r.wr ? ddr2_cmd_pkg::WR : ddr2_cmd_pkg::RD;
    c.ba       = r.bank;
    c.addr.row = {{ddr2_timing_pkg::COL_PAD_W{1'b0}}, r.col};    // A10 low, no auto precharge
    return c;
  endfunction

  function automatic ddr2_cmd_pkg::ddr2_cmd_t act_cmd(input ddr2_cmd_pkg::ddr2_req_t r);
    ddr2_cmd_pkg::ddr2_cmd_t c;
    c.cmd      = ddr2_cmd_pkg::ACT;
    c.ba       = r.bank;
    c.addr.row = r.row;
    return c;
  endfunction

  assign accept    = (state == S_IDLE) && req_strobe && !busy;
  assign row_hit   = open_vld[req.bank] && (open_row[req.bank] == req.row);
  assign act_req   = (state == S_IDLE) ? req : req_q;     // Closed bank uses the live request
  assign issue_act = (accept && !open_vld[req.bank]) || ((state == S_PRE_WAIT) && (dly == '0));
  assign issue_ref = ((state == S_IDLE) && !accept && ref_pending && (open_vld == '0)) ||
                     ((state == S_PREA_WAIT) && (dly == '0));
  assign ref_ack   = (state == S_RFC) && (dly == '0);
  assign cmd       = init_done ? cmd_q : init_cmd;        // Init owns the bus until it is done

  always_ff @(posedge ddr_clk_0) begin
    if (accept) begin
      req_q <= req;
    end
    if (issue_act) begin
      open_row[act_req.bank] <= act_req.row;
    end
  end

  always_ff @(posedge ddr_clk_0) begin
    if (ctrl_rst) begin
      state    <= S_INIT;
      dly      <= '0;
      open_vld <= '0;
      cmd_q    <= ddr2_cmd_pkg::CMD_NOP;
      busy     <= 1'b0;
    end else begin
      cmd_q <= ddr2_cmd_pkg::CMD_NOP;
      busy  <= 1'b1;
      if (dly != '0) begin
        dly <= dly - 1'b1;
      end
      case (state)
        S_INIT: begin
          if (init_done) begin
            state <= S_IDLE;
            busy  <= 1'b0;
          end
        end
        S_IDLE: begin
          if (accept) begin
            if (row_hit) begin
              cmd_q <= col_cmd(req);                      // Row already open
              state <= S_LAST;
            end else if (open_vld[req.bank]) begin
              cmd_q.cmd          <= ddr2_cmd_pkg::PRE;    // Wrong row open in this bank
              cmd_q.ba           <= req.bank;
              open_vld[req.bank] <= 1'b0;
              dly                <= DLY_W'(ddr2_timing_pkg::T_RP - 1);
              state              <= S_PRE_WAIT;
            end
          end else if (ref_pending) begin
            if (open_vld != '0) begin
              cmd_q.cmd <= ddr2_cmd_pkg::PREA;
              open_vld  <= '0;
              dly       <= DLY_W'(ddr2_timing_pkg::T_RP - 1);
              state     <= S_PREA_WAIT;
            end
          end else begin
            busy <= 1'b0;
          end
        end
        S_RFC: begin
          if (dly == '0) begin
            state <= S_IDLE;
            busy  <= 1'b0;
          end
        end
        S_ACT_WAIT: begin
          if (dly == '0) begin
            cmd_q <= col_cmd(req_q);
            state <= S_LAST;
          end
        end
        S_LAST: begin
          state <= S_IDLE;
          busy  <= ref_pending;                           // Refresh wins over the next request
        end
        default: begin
          state <= state;
        end
      endcase
      if (issue_act) begin
        cmd_q                  <= act_cmd(act_req);
        open_vld[act_req.bank] <= 1'b1;
        dly                    <= DLY_W'(ddr2_timing_pkg::T_RCD - 1);
        state                  <= S_ACT_WAIT;
      end
      if (issue_ref) begin
        cmd_q.cmd <= ddr2_cmd_pkg::REF;
        dly       <= DLY_W'(ddr2_timing_pkg::T_RFC - 1);
        state     <= S_RFC;
      end
    end
  end

endmodule

//--- verilog/ddr2_ctrl_top.sv
`timescale 1ns/1ps

module ddr2_ctrl_top #(
  parameter int REFI_CYCLES = 1040,
  parameter int RST_STAGES  = 8
) (
  input  logic                    ddr_clk_0,
  input  logic                    reset_int,
  input  logic                    usr_rst,
  input  logic                    pll_locked,
  input  logic                    req_strobe,
  input  ddr2_cmd_pkg::ddr2_req_t req,
  output logic                    busy,
  output logic                    init_done,
  output ddr2_cmd_pkg::ddr2_cmd_t cmd
);

  logic                    ctrl_rst;
  ddr2_cmd_pkg::ddr2_cmd_t init_cmd;
  logic                    ref_pending;
  logic                    ref_ack;

  ddr2_reset_gen #(
    .RST_STAGES (RST_STAGES)
  ) u_reset_gen (
    .ddr_clk_0  (ddr_clk_0),
    .reset_int  (reset_int),
    .usr_rst    (usr_rst),
    .pll_locked (pll_locked),
    .ctrl_rst   (ctrl_rst)
  );

  ddr2_init_seq u_init_seq (
    .ddr_clk_0 (ddr_clk_0),
    .ctrl_rst  (ctrl_rst),
    .init_cmd  (init_cmd),
    .init_done (init_done)
  );

  ddr2_refresh_timer #(
    .REFI_CYCLES (REFI_CYCLES)
  ) u_refresh_timer (
    .ddr_clk_0   (ddr_clk_0),
    .ctrl_rst    (ctrl_rst),
    .init_done   (init_done),
    .ref_ack     (ref_ack),
    .ref_pending (ref_pending)
  );

  ddr2_cmd_sched u_cmd_sched (
    .ddr_clk_0   (ddr_clk_0),
    .ctrl_rst    (ctrl_rst),
    .init_cmd    (init_cmd),
    .init_done   (init_done),
    .ref_pending (ref_pending),
    .req_strobe  (req_strobe),
    .req         (req),
    .busy        (busy),
    .ref_ack     (ref_ack),
    .cmd         (cmd)
  );

endmodule

//--- sim/tb_ddr2_ctrl.sv
`timescale 1ns/1ps

module tb_ddr2_ctrl;

  localparam int REFI_CYCLES = 1040;
  localparam int GOLD_WORDS  = 5 * 48;
  localparam int STEP_LIMIT  = 2 * REFI_CYCLES;      // Longest any single wait may take

  logic                    ddr_clk_0;
  logic                    reset_int;
  logic                    usr_rst;
  logic                    pll_locked;
  logic                    req_strobe;
  ddr2_cmd_pkg::ddr2_req_t req;
  logic                    busy;
  logic                    init_done;
  ddr2_cmd_pkg::ddr2_cmd_t cmd;

  logic [31:0]             gold [GOLD_WORDS];
  ddr2_cmd_pkg::ddr2_cmd_t seen_cmd [$];
  int                      seen_cyc [$];
  int                      cycle    = 0;
  int                      last_cyc = 0;
  int                      rec      = 0;

  ddr2_ctrl_top #(
    .REFI_CYCLES (REFI_CYCLES),
    .RST_STAGES  (8)
  ) u_ddr2_ctrl_top (
    .ddr_clk_0  (ddr_clk_0),
    .reset_int  (reset_int),
    .usr_rst    (usr_rst),
    .pll_locked (pll_locked),
    .req_strobe (req_strobe),
    .req        (req),
    .busy       (busy),
    .init_done  (init_done),
    .cmd        (cmd)
  );

  initial begin
    ddr_clk_0 = 1'b0;
    forever #10 ddr_clk_0 = ~ddr_clk_0;
  end

  // Every command on the bus is queued with the cycle it appeared in
  always @(negedge ddr_clk_0) begin
    cycle = cycle + 1;
    if (!reset_int && (cmd.cmd != ddr2_cmd_pkg::NOP)) begin   // Bus is unknown until reset lands
      seen_cmd.push_back(cmd);
      seen_cyc.push_back(cycle);
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_cmd(input string what, input ddr2_cmd_pkg::ddr2_cmd_t got,
                           input ddr2_cmd_pkg::ddr2_cmd_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s is %s ba=%0d addr=%h, expected %s ba=%0d addr=%h",
                $time, what, got.cmd.name(), got.ba, got.addr.row,
                exp.cmd.name(), exp.ba, exp.addr.row));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_spacing(input string what, input int gap, input int min_gap);
    if (gap < min_gap) begin
      abort_run($sformatf("At %0t the %s came %0d cycles after the last command, %0d needed",
                $time, what, gap, min_gap));
    end
  endtask

  function automatic logic [31:0] field(input int k);
    return gold[rec * 5 + k];
  endfunction

  function automatic ddr2_cmd_pkg::ddr2_cmd_t gold_cmd();
    ddr2_cmd_pkg::ddr2_cmd_t c;
    c.cmd      = ddr2_cmd_pkg::ddr2_cmd_e'(3'(field(1)));
    c.ba       = 2'(field(2));
    c.addr.row = 14'(field(3));
    return c;
  endfunction

  task automatic take_cmd(output ddr2_cmd_pkg::ddr2_cmd_t c, output int gap);
    int waited;
    waited = 0;
    while (seen_cmd.size() == 0) begin
      @(negedge ddr_clk_0);
      waited++;
      if (waited > STEP_LIMIT) abort_run("Timeout while waiting for a command on the bus");
    end
    c        = seen_cmd.pop_front();
    gap      = seen_cyc[0] - last_cyc;
    last_cyc = seen_cyc.pop_front();
  endtask

  task automatic wait_busy_low();
    int waited;
    waited = 0;
    while (busy !== 1'b0) begin
      @(negedge ddr_clk_0);
      waited++;
      if (waited > STEP_LIMIT) abort_run("Timeout while waiting for busy to go low");
    end
  endtask

  task automatic wait_init_done(input logic level);
    int waited;
    waited = 0;
    while (init_done !== level) begin
      @(negedge ddr_clk_0);
      waited++;
      if (waited > STEP_LIMIT) abort_run("Timeout while waiting for init_done to change");
    end
  endtask

  // Compares the bus against every following record of one kind
  task automatic check_stream(input int kind, input string what);
    ddr2_cmd_pkg::ddr2_cmd_t got;
    int                      gap;
    while (field(0) == kind) begin
      take_cmd(got, gap);
      check_cmd(what, got, gold_cmd());
      if (field(4) != 0) check_spacing(what, gap, int'(field(4)));
      rec++;
    end
  endtask

  task automatic wait_refresh();
    ddr2_cmd_pkg::ddr2_cmd_t got;
    ddr2_cmd_pkg::ddr2_cmd_t exp;
    int                      gap;
    exp = ddr2_cmd_pkg::CMD_NOP;
    if (field(1) != 0) begin
      exp.cmd = ddr2_cmd_pkg::PREA;                   // Rows were left open by the last burst
      take_cmd(got, gap);
      check_cmd("precharge before refresh", got, exp);
    end
    exp.cmd = ddr2_cmd_pkg::REF;
    take_cmd(got, gap);
    check_cmd("refresh", got, exp);
    if (field(1) != 0) check_spacing("refresh after PREA", gap, ddr2_timing_pkg::T_RP);
    rec++;
    wait_busy_low();
  endtask

  task automatic run_request(input logic dup);
    ddr2_cmd_pkg::ddr2_req_t r;
    int                      n_exp;
    int                      waited;
    r.wr   = 1'(field(1));
    r.bank = 2'(field(2));
    r.row  = 14'(field(3));
    r.col  = 10'(field(4));
    n_exp  = 0;
    while (gold[(rec + 1 + n_exp) * 5] == 32'd4) n_exp++;
    rec++;
    wait_busy_low();
    @(posedge ddr_clk_0);
    #2;
    req_strobe = 1'b1;
    req        = r;
    @(posedge ddr_clk_0);
    #2;
    req_strobe = dup;                                 // Lands while busy is already high
    req        = '{wr: ~r.wr, bank: r.bank + 2'd1, row: ~r.row, col: r.col};
    waited     = 0;
    while (seen_cmd.size() < n_exp) begin
      @(negedge ddr_clk_0);
      check_flag("busy before the column command", busy, 1'b1);
      @(posedge ddr_clk_0);
      #2;
      req_strobe = 1'b0;
      waited++;
      if (waited > STEP_LIMIT) abort_run("Timeout while waiting for the request's commands");
    end
    check_stream(4, "request command");
  endtask

  initial begin
    int init_rec;
    reset_int  = 1'b1;
    usr_rst    = 1'b0;
    pll_locked = 1'b0;
    req_strobe = 1'b0;
    req        = '0;
    $readmemh("sim/ddr2_golden.txt", gold);
    repeat (3) @(posedge ddr_clk_0);
    #2;
    reset_int = 1'b0;
    repeat (60) begin                                 // Without lock the controller stays quiet
      @(negedge ddr_clk_0);
      check_flag("init_done without lock", init_done, 1'b0);
      check_cmd("bus without lock", cmd, ddr2_cmd_pkg::CMD_NOP);
    end
    @(posedge ddr_clk_0);
    #2;
    pll_locked = 1'b1;
    init_rec   = rec;
    check_stream(1, "init command");
    check_flag("busy during init", busy, 1'b1);
    wait_init_done(1'b1);
    @(posedge ddr_clk_0);
    #2;
    usr_rst = 1'b1;                                   // User reset restarts the power-up list
    @(posedge ddr_clk_0);
    #2;
    usr_rst = 1'b0;
    wait_init_done(1'b0);
    rec = init_rec;
    check_stream(1, "init command after user reset");
    wait_init_done(1'b1);
    while (field(0) != 32'hf) begin
      case (field(0))
        32'd2:   wait_refresh();
        32'd3:   run_request(1'b0);
        32'd6:   run_request(1'b1);
        default: abort_run("The golden file holds a record of unknown kind");
      endcase
    end
    repeat (20) @(negedge ddr_clk_0);
    if (seen_cmd.size() != 0) begin
      abort_run("Commands appeared on the bus after the last request");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- compile.f
verilog/ddr2_timing_pkg.sv
verilog/ddr2_cmd_pkg.sv
verilog/ddr2_reset_gen.sv
verilog/ddr2_init_seq.sv
verilog/ddr2_refresh_timer.sv
verilog/ddr2_cmd_sched.sv
verilog/ddr2_ctrl_top.sv
sim/tb_ddr2_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f compile.f \
  --top-module tb_ddr2_ctrl -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

//--- sim/ddr2_golden.txt
// Columns in hex: kind op ba addr arg
// kind 1 init command, 2 wait for refresh (op 1 wants PREA first), 3 request, 6 request
// plus a strobe while busy, 4 expected command, f end; arg is min gap, or the column of a request
1 4 0 0000 0
1 1 2 0000 4
1 1 3 0000 2
1 1 1 0004 2
1 1 0 0742 2
1 4 0 0000 2
1 2 0 0000 4
1 2 0 0000 1a
1 1 0 0642 1a
1 1 1 0004 2
2 0 0 0000 0
3 0 0 0123 010  // Read to a closed bank
4 5 0 0123 0
4 7 0 0010 4
6 1 0 0123 020  // Write hit, the second strobe must be ignored
4 6 0 0020 0
3 1 0 0456 008  // Write conflict in bank 0
4 3 0 0000 0
4 5 0 0456 4
4 6 0 0008 4
3 0 1 1abc 3ff  // Read to closed bank 1
4 5 1 1abc 0
4 7 1 03ff 4
2 1 0 0000 0
3 0 0 0456 001  // Row was open before the refresh, so the bank is closed now
4 5 0 0456 0
4 7 0 0001 4
2 1 0 0000 0
2 0 0 0000 0
f 0 0 0000 0
